// File: verilog/rv32i_types.sv
package rv32i_types;

    typedef logic [31:0] rv32i_word;    // data, address and instruction
    typedef logic [4:0]  rv32i_reg;     // register index
    typedef logic [3:0]  mem_byte_en_t; // one bit per byte lane

    // major opcodes that the pipeline decodes
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        f3_add  = 3'b000, // add / sub
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101, // srl / sra
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } funct3_alu;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } funct3_store;

    // R-type layout, the other formats share the rs1/funct3/rd/opcode positions
    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } instr_fields_t;

    localparam logic [6:0] funct7_alt = 7'b0100000; // sub, sra
    localparam logic [2:0] funct3_lw  = 3'b010;
    localparam rv32i_word  nop_instr  = 32'h0000_0013; // addi x0, x0, 0

endpackage

// File: verilog/control_word_types.sv
package control_word_types;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_ops;

    typedef enum logic {a_rs1 = 1'b0, a_pc = 1'b1} alu_a_sel_t;
    typedef enum logic {b_rs2 = 1'b0, b_imm = 1'b1} alu_b_sel_t;
    typedef enum logic {wb_alu = 1'b0, wb_mem = 1'b1} wb_sel_t;

    // everything later stages need, produced once in decode
    typedef struct packed {
        alu_ops                    aluop;
        alu_a_sel_t                alu_a_sel;
        alu_b_sel_t                alu_b_sel;
        logic                      mem_read;
        logic                      mem_write;
        rv32i_types::funct3_store  store_size;
        logic                      reg_write;
        wb_sel_t                   wb_sel;
        rv32i_types::rv32i_reg     rs1;
        rv32i_types::rv32i_reg     rs2;
        rv32i_types::rv32i_reg     rd;
    } control_word_t;

    localparam int CONTROL_WORD_SIZE = $bits(control_word_t);

    // all zero: add, rs1/rs2 operands, no memory access, no write to x0
    localparam control_word_t ctrl_nop = control_word_t'({CONTROL_WORD_SIZE{1'b0}});

endpackage

// File: verilog/pipe_if.sv
`timescale 1ns/100ps

// ID/EX stage register contents
interface id_ex_if;
    import rv32i_types::*;
    import control_word_types::*;

    control_word_t ctrl;
    rv32i_word     pc;       // pc of the instruction itself
    rv32i_word     rs1_data;
    rv32i_word     rs2_data;
    rv32i_word     imm;      // already sign extended / shifted

    modport stage_out (
        output ctrl, pc, rs1_data, rs2_data, imm
    );

    modport stage_in (
        input ctrl, pc, rs1_data, rs2_data, imm
    );
endinterface

// EX/MEM stage register contents
interface ex_mem_if;
    import rv32i_types::*;
    import control_word_types::*;

    control_word_t ctrl;
    rv32i_word     alu_out;  // result or memory address
    rv32i_word     rs2_data; // store data after forwarding

    // execute writes these and reads them back for forwarding
    modport stage_out (
        output ctrl, alu_out, rs2_data
    );

    modport stage_in (
        input ctrl, alu_out, rs2_data
    );
endinterface

// File: verilog/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_types::rv32i_word i_mem_rdata,
    output rv32i_types::rv32i_word i_mem_address,
    output logic                   i_mem_read,
    output rv32i_types::rv32i_word if_pc,
    output rv32i_types::rv32i_word if_ir
);
    import rv32i_types::*;

    rv32i_word pc;
    logic      fetch_en; // first cycle out of reset fetches address 0

    assign i_mem_address = pc;
    assign i_mem_read    = fetch_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= '0;
            fetch_en <= 1'b0;
            if_ir    <= nop_instr;
        end else begin
            fetch_en <= 1'b1;
            if (fetch_en) pc <= pc + 32'd4; // no branches, always sequential
            if_ir <= fetch_en ? i_mem_rdata : nop_instr;
        end
    end

    always_ff @(posedge clk) begin
        if_pc <= pc; // payload only
    end

    // sequential fetch keeps the pc on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_en |=> (pc[1:0] == 2'b00) && (pc == $past(pc) + 32'd4));

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_types::rv32i_reg  rs1,
    input  rv32i_types::rv32i_reg  rs2,
    output rv32i_types::rv32i_word rs1_data,
    output rv32i_types::rv32i_word rs2_data,
    input  logic                   wb_we,
    input  rv32i_types::rv32i_reg  wb_rd,
    input  rv32i_types::rv32i_word wb_data
);
    import rv32i_types::*;

    rv32i_word regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write in the same cycle wins over the stored value
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_types::rv32i_word if_pc,
    input  rv32i_types::rv32i_word if_ir,
    input  logic                   wb_we,
    input  rv32i_types::rv32i_reg  wb_rd,
    input  rv32i_types::rv32i_word wb_data,
    id_ex_if.stage_out             id_ex
);
    import rv32i_types::*;
    import control_word_types::*;

    instr_fields_t fld;
    control_word_t ctrl;
    rv32i_word     imm_i, imm_s, imm_u;
    rv32i_word     imm;
    rv32i_word     rs1_data, rs2_data;
    logic          f7_zero, f7_alt;

    // funct3 plus the alt bit of funct7 to alu operation
    function automatic alu_ops alu_decode(input logic [2:0] f3, input logic alt);
        case (funct3_alu'(f3))
            f3_add:  alu_decode = alt ? alu_sub : alu_add;
            f3_sll:  alu_decode = alu_sll;
            f3_slt:  alu_decode = alu_slt;
            f3_sltu: alu_decode = alu_sltu;
            f3_xor:  alu_decode = alu_xor;
            f3_sr:   alu_decode = alt ? alu_sra : alu_srl;
            f3_or:   alu_decode = alu_or;
            default: alu_decode = alu_and;
        endcase
    endfunction

    assign fld     = if_ir;
    assign f7_zero = (fld.funct7 == 7'b0);
    assign f7_alt  = (fld.funct7 == funct7_alt);

    assign imm_i = {{20{if_ir[31]}}, if_ir[31:20]};
    assign imm_s = {{20{if_ir[31]}}, if_ir[31:25], if_ir[11:7]};
    assign imm_u = {if_ir[31:12], 12'h000};

    always_comb begin
        ctrl = ctrl_nop; // anything unrecognised falls through as a nop
        imm  = imm_i;
        case (rv32i_opcode'(fld.opcode))
            op_reg: begin
                // funct7 alt only legal for sub and sra
                if (f7_zero || (f7_alt && (fld.funct3 == f3_add || fld.funct3 == f3_sr))) begin
                    ctrl.aluop     = alu_decode(fld.funct3, f7_alt);
                    ctrl.reg_write = 1'b1;
                    ctrl.rs1       = fld.rs1;
                    ctrl.rs2       = fld.rs2;
                    ctrl.rd        = fld.rd;
                end
            end
            op_imm: begin
                // shift immediates carry funct7 in the upper imm bits
                if ((fld.funct3 != f3_sll || f7_zero) &&
                    (fld.funct3 != f3_sr || f7_zero || f7_alt)) begin
                    ctrl.aluop     = alu_decode(fld.funct3, (fld.funct3 == f3_sr) && f7_alt);
                    ctrl.alu_b_sel = b_imm;
                    ctrl.reg_write = 1'b1;
                    ctrl.rs1       = fld.rs1;
                    ctrl.rd        = fld.rd;
                end
            end
            op_lui: begin
                ctrl.alu_b_sel = b_imm; // x0 + imm
                ctrl.reg_write = 1'b1;
                ctrl.rd        = fld.rd;
                imm            = imm_u;
            end
            op_auipc: begin
                ctrl.alu_a_sel = a_pc;
                ctrl.alu_b_sel = b_imm;
                ctrl.reg_write = 1'b1;
                ctrl.rd        = fld.rd;
                imm            = imm_u;
            end
            op_load: begin
                if (fld.funct3 == funct3_lw) begin // word loads only
                    ctrl.alu_b_sel = b_imm;
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_mem;
                    ctrl.rs1       = fld.rs1;
                    ctrl.rd        = fld.rd;
                end
            end
            op_store: begin
                if (fld.funct3 == sb || fld.funct3 == sh || fld.funct3 == sw) begin
                    ctrl.alu_b_sel  = b_imm;
                    ctrl.mem_write  = 1'b1;
                    ctrl.store_size = funct3_store'(fld.funct3);
                    ctrl.rs1        = fld.rs1;
                    ctrl.rs2        = fld.rs2;
                    imm             = imm_s;
                end
            end
            default: ;
        endcase
    end

    // read ports indexed from the control word so unused fields read x0
    regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) id_ex.ctrl <= ctrl_nop;
        else        id_ex.ctrl <= ctrl;
    end

    always_ff @(posedge clk) begin
        id_ex.pc       <= if_pc;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
    end

    a_store_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        id_ex.ctrl.mem_write |-> !id_ex.ctrl.reg_write);

endmodule

// File: verilog/alu.sv
`timescale 1ns/100ps

module alu (
    input  control_word_types::alu_ops aluop,
    input  rv32i_types::rv32i_word     a,
    input  rv32i_types::rv32i_word     b,
    output rv32i_types::rv32i_word     f
);
    import control_word_types::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // upper bits of b ignored for shifts

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'b0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = $unsigned($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = a + b;
        endcase
    end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    id_ex_if.stage_in              id_ex,
    ex_mem_if.stage_out            ex_mem,
    input  logic                   wb_we,
    input  rv32i_types::rv32i_reg  wb_rd,
    input  rv32i_types::rv32i_word wb_data
);
    import rv32i_types::*;
    import control_word_types::*;

    logic      mem_fwd_ok; // EX/MEM holds a usable alu result
    logic      fwd_mem_rs1, fwd_mem_rs2;
    logic      fwd_wb_rs1, fwd_wb_rs2;
    rv32i_word rs1_val, rs2_val;
    rv32i_word alu_a, alu_b, alu_f;

    // load data is not ready in EX/MEM, program avoids load-use
    assign mem_fwd_ok  = ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read &&
                         ex_mem.ctrl.rd != '0;
    assign fwd_mem_rs1 = mem_fwd_ok && (ex_mem.ctrl.rd == id_ex.ctrl.rs1);
    assign fwd_mem_rs2 = mem_fwd_ok && (ex_mem.ctrl.rd == id_ex.ctrl.rs2);
    assign fwd_wb_rs1  = wb_we && wb_rd != '0 && (wb_rd == id_ex.ctrl.rs1);
    assign fwd_wb_rs2  = wb_we && wb_rd != '0 && (wb_rd == id_ex.ctrl.rs2);

    // youngest result first
    assign rs1_val = fwd_mem_rs1 ? ex_mem.alu_out :
                     fwd_wb_rs1  ? wb_data : id_ex.rs1_data;
    assign rs2_val = fwd_mem_rs2 ? ex_mem.alu_out :
                     fwd_wb_rs2  ? wb_data : id_ex.rs2_data;

    assign alu_a = (id_ex.ctrl.alu_a_sel == a_pc)  ? id_ex.pc  : rs1_val; // auipc
    assign alu_b = (id_ex.ctrl.alu_b_sel == b_imm) ? id_ex.imm : rs2_val;

    alu i_alu (
        .aluop (id_ex.ctrl.aluop),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) ex_mem.ctrl <= ctrl_nop;
        else        ex_mem.ctrl <= id_ex.ctrl;
    end

    always_ff @(posedge clk) begin
        ex_mem.alu_out  <= alu_f;
        ex_mem.rs2_data <= rs2_val; // store data with forwarding applied
    end

    // a load in EX/MEM has no data yet, so the next instruction must not read its rd
    a_no_load_use: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_mem.ctrl.mem_read && ex_mem.ctrl.rd != '0) |->
            (ex_mem.ctrl.rd != id_ex.ctrl.rs1 && ex_mem.ctrl.rd != id_ex.ctrl.rs2));

endmodule

// File: verilog/mem_wb_stage.sv
`timescale 1ns/100ps

module mem_wb_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    ex_mem_if.stage_in                ex_mem,
    output rv32i_types::rv32i_word    d_mem_address,
    output rv32i_types::rv32i_word    d_mem_wdata,
    output rv32i_types::mem_byte_en_t mem_byte_en,
    output logic                      d_mem_read,
    output logic                      d_mem_write,
    input  rv32i_types::rv32i_word    d_mem_rdata,
    output logic                      wb_we,
    output rv32i_types::rv32i_reg     wb_rd,
    output rv32i_types::rv32i_word    wb_data
);
    import rv32i_types::*;
    import control_word_types::*;

    logic [1:0]   offs; // byte offset within the word
    rv32i_word    st;
    mem_byte_en_t lanes;

    assign offs          = ex_mem.alu_out[1:0];
    assign st            = ex_mem.rs2_data;
    assign d_mem_address = {ex_mem.alu_out[31:2], 2'b00};
    assign d_mem_read    = ex_mem.ctrl.mem_read;
    assign d_mem_write   = ex_mem.ctrl.mem_write;

    // data copied into every lane, enables pick the right one
    always_comb begin
        case (ex_mem.ctrl.store_size)
            sb: begin
                d_mem_wdata = {4{st[7:0]}};
                lanes       = mem_byte_en_t'(4'b0001 << offs);
            end
            sh: begin
                d_mem_wdata = {2{st[15:0]}};
                lanes       = offs[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                d_mem_wdata = st;
                lanes       = 4'b1111;
            end
        endcase
    end

    assign mem_byte_en = ex_mem.ctrl.mem_write ? lanes : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) wb_we <= 1'b0;
        else        wb_we <= ex_mem.ctrl.reg_write;
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_mem.ctrl.rd;
        wb_data <= (ex_mem.ctrl.wb_sel == wb_mem) ? d_mem_rdata : ex_mem.alu_out;
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(d_mem_read && d_mem_write));

endmodule

// File: verilog/datapath.sv
`timescale 1ns/100ps

module datapath (
    input  logic                      clk,
    input  logic                      rst_n,

    input  rv32i_types::rv32i_word    i_mem_rdata,
    output rv32i_types::rv32i_word    i_mem_address,
    output logic                      i_mem_read,

    input  rv32i_types::rv32i_word    d_mem_rdata,
    output rv32i_types::rv32i_word    d_mem_wdata,
    output rv32i_types::rv32i_word    d_mem_address,
    output logic                      d_mem_read,
    output logic                      d_mem_write,
    output rv32i_types::mem_byte_en_t mem_byte_en
);
    import rv32i_types::*;

    rv32i_word if_pc, if_ir; // IF/ID outputs
    logic      wb_we;        // writeback bus
    rv32i_reg  wb_rd;
    rv32i_word wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    fetch_stage i_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_mem_rdata   (i_mem_rdata),
        .i_mem_address (i_mem_address),
        .i_mem_read    (i_mem_read),
        .if_pc         (if_pc),
        .if_ir         (if_ir)
    );

    decode_stage i_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .if_pc   (if_pc),
        .if_ir   (if_ir),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .id_ex   (id_ex.stage_out)
    );

    execute_stage i_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .id_ex   (id_ex.stage_in),
        .ex_mem  (ex_mem.stage_out),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    mem_wb_stage i_mem_wb (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_mem        (ex_mem.stage_in),
        .d_mem_address (d_mem_address),
        .d_mem_wdata   (d_mem_wdata),
        .mem_byte_en   (mem_byte_en),
        .d_mem_read    (d_mem_read),
        .d_mem_write   (d_mem_write),
        .d_mem_rdata   (d_mem_rdata),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1; // released just after the edge, like every driven input
    end

endmodule

// File: testbench/tb_datapath.sv
`timescale 1ns/100ps

module tb_datapath;
    import rv32i_types::*;

    localparam int PROG_LEN   = 256; // random part of the program
    localparam int IMEM_WORDS = 512;
    localparam int DMEM_WORDS = 256; // 1 KiB of data
    localparam int TIMEOUT    = 2000;

    logic         clk;
    logic         rst_n;
    rv32i_word    i_mem_rdata;
    rv32i_word    i_mem_address;
    logic         i_mem_read;
    rv32i_word    d_mem_rdata;
    rv32i_word    d_mem_wdata;
    rv32i_word    d_mem_address;
    logic         d_mem_read;
    logic         d_mem_write;
    mem_byte_en_t mem_byte_en;

    rv32i_word    imem [0:IMEM_WORDS-1];
    rv32i_word    dmem [0:DMEM_WORDS-1];
    rv32i_word    xr [0:31];               // model register file
    logic [7:0]   mb [0:4*DMEM_WORDS-1];   // model data memory, bytes
    rv32i_word    exp_addr_q [$];          // expected stores, in order
    mem_byte_en_t exp_be_q [$];
    rv32i_word    exp_data_q [$];          // already placed in its lanes
    rv32i_word    seed;
    rv32i_word    exp_pc;
    int           errors;
    int           stores_seen;
    int           stores_expected;
    logic         first_fetch_done;
    logic         ok;

    tb_clock i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    datapath i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_mem_rdata   (i_mem_rdata),
        .i_mem_address (i_mem_address),
        .i_mem_read    (i_mem_read),
        .d_mem_rdata   (d_mem_rdata),
        .d_mem_wdata   (d_mem_wdata),
        .d_mem_address (d_mem_address),
        .d_mem_read    (d_mem_read),
        .d_mem_write   (d_mem_write),
        .mem_byte_en   (mem_byte_en)
    );

    // both memories answer in the same cycle
    always_comb begin
        i_mem_rdata = nop_instr; // past the program, or not fetching
        if (i_mem_read && i_mem_address < 32'(4 * IMEM_WORDS))
            i_mem_rdata = imem[i_mem_address[10:2]];
    end

    always_comb begin
        d_mem_rdata = '0;
        if (d_mem_read) d_mem_rdata = dmem[d_mem_address[9:2]];
    end

    function automatic rv32i_word next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16); // fold the better high bits down
    endfunction

    function automatic rv32i_reg pick_reg();
        rv32i_word r;
        r = next_rand();
        return r[31] ? {2'b00, r[9:7]} : r[4:0]; // x0..x7 often, more dependencies
    endfunction

    // odd multiplier, so every word address gives its own value
    function automatic rv32i_word fill_word(input rv32i_word idx);
        return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic rv32i_word byte_mask(input mem_byte_en_t be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic rv32i_word r_format(input logic [6:0] f7, input rv32i_reg rs2,
                                           input rv32i_reg rs1, input logic [2:0] f3,
                                           input rv32i_reg rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic rv32i_word i_format(input logic [11:0] imm, input rv32i_reg rs1,
                                           input logic [2:0] f3, input rv32i_reg rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv32i_word s_format(input logic [11:0] imm, input rv32i_reg rs2,
                                           input rv32i_reg rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic rv32i_word u_format(input logic [19:0] imm, input rv32i_reg rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // RV32I semantics of the ALU group
    function automatic rv32i_word spec_alu(input logic [2:0] f3, input logic alt,
                                           input rv32i_word a, input rv32i_word b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? rv32i_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        rv32i_word   r;
        rv32i_word   addr;
        rv32i_reg    rd, rs1, rs2, last_ld;
        logic [2:0]  f3, sz;
        logic [11:0] imm;
        logic        alt;
        last_ld = '0;
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = nop_instr;
        for (int i = 0; i < PROG_LEN; i++) begin
            r   = next_rand();
            rd  = pick_reg();
            rs1 = pick_reg();
            rs2 = pick_reg();
            if (last_ld != '0 && rs1 == last_ld) rs1 = '0; // no load-use
            if (last_ld != '0 && rs2 == last_ld) rs2 = '0;
            last_ld = '0;
            f3   = r[14:12];
            alt  = r[20] && (f3 == 3'b000 || f3 == 3'b101); // sub / sra / srai
            addr = {22'b0, r[31:22]}; // byte address 0..1023
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                    imem[i] = r_format((alt ? funct7_alt : 7'b0), rs2, rs1, f3, rd);
                end
                4'd5, 4'd6, 4'd7, 4'd8: begin
                    // shifts keep funct7 in the top of the immediate
                    imm = (f3 == 3'b001 || f3 == 3'b101) ?
                          {(alt ? funct7_alt : 7'b0), r[27:23]} : r[31:20];
                    imem[i] = i_format(imm, rs1, f3, rd, op_imm);
                end
                4'd9:  imem[i] = u_format(r[31:12], rd, op_lui);
                4'd10: imem[i] = u_format(r[31:12], rd, op_auipc);
                4'd11, 4'd12: begin
                    imem[i] = i_format({addr[11:2], 2'b00}, 5'd0, funct3_lw, rd, op_load);
                    last_ld = rd;
                end
                default: begin
                    sz  = (r[5:4] == 2'b11) ? 3'b010 : {1'b0, r[5:4]};
                    imm = (sz == 3'b000) ? addr[11:0] :
                          (sz == 3'b001) ? {addr[11:1], 1'b0} : {addr[11:2], 2'b00};
                    imem[i] = s_format(imm, rs2, 5'd0, sz);
                end
            endcase
        end
        // one nop, then dump x1..x31 to words 1..31
        for (int k = 1; k < 32; k++)
            imem[PROG_LEN + k] = s_format(12'(4 * k), rv32i_reg'(k), 5'd0, sw);
    endtask

    // in-order ISS over the whole instruction memory
    task automatic model_program();
        rv32i_word    ir, a, b, res, addr, data, word;
        rv32i_word    imm_i, imm_s, imm_u;
        logic [2:0]   f3;
        rv32i_reg     rd;
        mem_byte_en_t be;
        logic         wr;
        int           base;
        for (int k = 0; k < 32; k++) xr[k] = '0;
        for (int w = 0; w < DMEM_WORDS; w++) begin
            word = fill_word(rv32i_word'(w));
            for (int j = 0; j < 4; j++) mb[4 * w + j] = word[8 * j +: 8];
        end
        for (int i = 0; i < IMEM_WORDS; i++) begin
            ir    = imem[i];
            f3    = ir[14:12];
            rd    = ir[11:7];
            a     = xr[ir[19:15]];
            b     = xr[ir[24:20]];
            imm_i = {{20{ir[31]}}, ir[31:20]};
            imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            imm_u = {ir[31:12], 12'h000};
            wr    = 1'b1;
            res   = '0;
            case (ir[6:0])
                op_reg:   res = spec_alu(f3, ir[30], a, b);
                op_imm:   res = spec_alu(f3, ir[30] && f3 == 3'b101, a, imm_i);
                op_lui:   res = imm_u;
                op_auipc: res = rv32i_word'(4 * i) + imm_u;
                op_load: begin
                    addr = a + imm_i;
                    base = int'(addr[9:0]);
                    res  = {mb[base + 3], mb[base + 2], mb[base + 1], mb[base]};
                end
                op_store: begin
                    wr   = 1'b0;
                    addr = a + imm_s;
                    base = int'({addr[9:2], 2'b00});
                    case (f3)
                        3'b000:  be = 4'b0001 << addr[1:0];
                        3'b001:  be = 4'b0011 << addr[1:0];
                        default: be = 4'b1111;
                    endcase
                    data = b << {addr[1:0], 3'b000}; // move into its lane
                    for (int j = 0; j < 4; j++)
                        if (be[j]) mb[base + j] = data[8 * j +: 8];
                    exp_addr_q.push_back({addr[31:2], 2'b00});
                    exp_be_q.push_back(be);
                    exp_data_q.push_back(data);
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != '0) xr[rd] = res; // x0 never written
        end
    endtask

    task automatic note_failure(input string msg);
        errors = errors + 1;
        $display("ERROR: %s", msg);
    endtask

    task automatic check_word(input string name, input rv32i_word exp, input rv32i_word act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_byte_en(input string name, input mem_byte_en_t exp,
                                 input mem_byte_en_t act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic match_store();
        rv32i_word    a, d, m;
        mem_byte_en_t be;
        if (exp_addr_q.size() == 0) begin
            note_failure($sformatf("store to %h with no store left in the model",
                                   d_mem_address));
        end else begin
            a  = exp_addr_q.pop_front();
            be = exp_be_q.pop_front();
            d  = exp_data_q.pop_front();
            m  = byte_mask(be); // only enabled lanes carry data
            check_word($sformatf("store %0d address", stores_seen), a, d_mem_address);
            check_byte_en($sformatf("store %0d byte enable", stores_seen), be, mem_byte_en);
            check_word($sformatf("store %0d data", stores_seen), d & m, d_mem_wdata & m);
        end
        // written mid cycle, the next load already sees it
        m = byte_mask(mem_byte_en);
        dmem[d_mem_address[9:2]] = (dmem[d_mem_address[9:2]] & ~m) | (d_mem_wdata & m);
        stores_seen = stores_seen + 1;
    endtask

    // outputs sampled on the falling edge, half a cycle after they settle
    initial begin
        @(posedge clk); // first edge loads the synchronous reset values
        forever begin
            @(negedge clk);
            if (rst_n !== 1'b1) begin
                if ((i_mem_read | d_mem_read | d_mem_write) !== 1'b0)
                    note_failure("memory strobe not low during reset");
            end else begin
                if (!first_fetch_done) begin
                    check_word("first fetch address", '0, i_mem_address);
                    first_fetch_done = 1'b1;
                end
                if (i_mem_read) begin
                    check_word("fetch address", exp_pc, i_mem_address);
                    exp_pc = exp_pc + 32'd4;
                end
                if (d_mem_write) match_store();
            end
        end
    end

    task automatic reset_release(output logic done);
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n = n + 1;
        end
        done = (rst_n === 1'b1);
        if (!done) note_failure("reset was never released");
    endtask

    task automatic drain_stores(output logic done);
        int n;
        n = 0;
        while (stores_seen < stores_expected && n < TIMEOUT) begin
            @(posedge clk);
            n = n + 1;
        end
        done = (stores_seen >= stores_expected);
        if (!done)
            note_failure($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                                   TIMEOUT, stores_seen, stores_expected));
    endtask

    task automatic final_report();
        $display("errors: %0d  stores seen: %0d of %0d", errors, stores_seen, stores_expected);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    initial begin
        seed             = 32'h1daa_9fb8;
        errors           = 0;
        stores_seen      = 0;
        exp_pc           = '0;
        first_fetch_done = 1'b0;
        build_program();
        for (int w = 0; w < DMEM_WORDS; w++) dmem[w] = fill_word(rv32i_word'(w));
        model_program();
        stores_expected = exp_addr_q.size();
        reset_release(ok);
        if (ok) drain_stores(ok);
        if (ok) begin
            repeat (8) @(posedge clk); // a stray late store would show up here
            if (stores_seen != stores_expected)
                note_failure($sformatf("%0d stores seen, model has %0d",
                                       stores_seen, stores_expected));
            if (exp_addr_q.size() != 0) note_failure("model store queue not empty at end");
        end
        final_report();
    end

endmodule

// File: verilog.f
verilog/rv32i_types.sv
verilog/control_word_types.sv
verilog/pipe_if.sv
verilog/fetch_stage.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/datapath.sv
testbench/tb_clock.sv
testbench/tb_datapath.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the testbench reports a pass
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module tb_datapath -o tb_sim &&
out=$(./obj_dir/tb_sim); printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TB PASSED" && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
